/* hw/fcpu_mem_pkg.sv */
package fcpu_mem_pkg;

   localparam int data_w = 32; // data and address
   localparam int tag_w  = 4;  // rob id and cdb tag

   typedef enum logic [2:0] {
      op_load       = 3'd0,
      op_load_byte  = 3'd1,
      op_store      = 3'd2,
      op_store_byte = 3'd3,
      op_output     = 3'd4
   } opcode_t;

   // opcodes that go through the store buffer and return nothing
   function automatic logic is_store(opcode_t op);
      logic res;
      case (op)
         op_store, op_store_byte, op_output: res = 1'b1;
         default:                            res = 1'b0;
      endcase
      return res;
   endfunction

endpackage

/* hw/mem_unit_if.sv */
interface addr_if;
   logic                            valid;
   logic                            ready;
   logic [fcpu_mem_pkg::tag_w-1:0]  rob_id;
   fcpu_mem_pkg::opcode_t           opcode;
   logic [fcpu_mem_pkg::data_w-1:0] address;
   logic [fcpu_mem_pkg::data_w-1:0] store_data_unused; // zero word, feeds bypass o_mem_data

   modport src (
      output valid, rob_id, opcode, address, store_data_unused,
      input  ready
   );
   modport dst (
      input  valid, rob_id, opcode, address, store_data_unused,
      output ready
   );
   modport mon (
      input valid, ready, rob_id, opcode, address
   );
endinterface

interface sb_head_if;
   logic                            head_valid;  // committed, address and data known
   logic [fcpu_mem_pkg::tag_w-1:0]  head_rob_id;
   fcpu_mem_pkg::opcode_t           head_opcode;
   logic [fcpu_mem_pkg::data_w-1:0] head_address;
   logic [fcpu_mem_pkg::data_w-1:0] head_data;
   logic                            pop;

   logic [fcpu_mem_pkg::data_w-1:0] query_address;
   logic                            match_hit;   // youngest matching store
   logic                            match_ready;
   logic [fcpu_mem_pkg::data_w-1:0] match_data;

   modport src (
      output head_valid, head_rob_id, head_opcode, head_address, head_data,
      output match_hit, match_ready, match_data,
      input  pop, query_address
   );
   modport dst (
      input  head_valid, head_rob_id, head_opcode, head_address, head_data,
      input  match_hit, match_ready, match_data,
      output pop, query_address
   );
endinterface

/* hw/address_station.sv */
module address_station #(
   parameter int station_depth = 4
) (
   input  logic                            clk,
   input  logic                            nrst,
   input  logic                            i_valid,
   input  logic [fcpu_mem_pkg::tag_w-1:0]  i_rob_id,
   input  fcpu_mem_pkg::opcode_t           i_opcode,
   input  logic [fcpu_mem_pkg::data_w-1:0] i_base,
   input  logic [fcpu_mem_pkg::tag_w-1:0]  i_base_tag,
   input  logic                            i_base_filled,
   input  logic [fcpu_mem_pkg::data_w-1:0] i_offset,
   input  logic [fcpu_mem_pkg::tag_w-1:0]  i_offset_tag,
   input  logic                            i_offset_filled,
   output logic                            o_ready,
   input  logic                            i_cdb_valid,
   input  logic [fcpu_mem_pkg::tag_w-1:0]  i_cdb_tag,
   input  logic [fcpu_mem_pkg::data_w-1:0] i_cdb_data,
   addr_if.src                             addr
);
   localparam int ptr_w = $clog2(station_depth);

   logic [ptr_w-1:0]                head;
   logic [ptr_w-1:0]                tail;
   logic [station_depth-1:0]        used;
   logic [station_depth-1:0]        base_ok;
   logic [station_depth-1:0]        offset_ok;
   logic [station_depth-1:0]        base_hit;
   logic [station_depth-1:0]        offset_hit;
   logic [fcpu_mem_pkg::tag_w-1:0]  rob_id_q [station_depth];
   fcpu_mem_pkg::opcode_t           opcode_q [station_depth];
   logic [fcpu_mem_pkg::data_w-1:0] base_q [station_depth];
   logic [fcpu_mem_pkg::data_w-1:0] offset_q [station_depth];
   logic [fcpu_mem_pkg::tag_w-1:0]  base_tag_q [station_depth];
   logic [fcpu_mem_pkg::tag_w-1:0]  offset_tag_q [station_depth];
   logic                            push;
   logic                            pop;
   logic                            in_base_hit;
   logic                            in_offset_hit;

   assign o_ready = !used[tail]; // tail slot busy means full
   assign push    = i_valid && o_ready;
   assign pop     = addr.valid && addr.ready;

   // operand broadcast in the same cycle as dispatch
   assign in_base_hit   = i_cdb_valid && !i_base_filled && i_cdb_tag == i_base_tag;
   assign in_offset_hit = i_cdb_valid && !i_offset_filled && i_cdb_tag == i_offset_tag;

   always_comb begin
      for (int i = 0; i < station_depth; i++) begin
         base_hit[i]   = used[i] && !base_ok[i] && i_cdb_valid && base_tag_q[i] == i_cdb_tag;
         offset_hit[i] = used[i] && !offset_ok[i] && i_cdb_valid &&
                         offset_tag_q[i] == i_cdb_tag;
      end
   end

   // only the head may issue, so order is kept
   assign addr.valid             = used[head] && base_ok[head] && offset_ok[head];
   assign addr.rob_id            = rob_id_q[head];
   assign addr.opcode            = opcode_q[head];
   assign addr.address           = base_q[head] + offset_q[head];
   assign addr.store_data_unused = '0;

   always_ff @(posedge clk) begin
      if (nrst) begin
         head      <= '0;
         tail      <= '0;
         used      <= '0;
         base_ok   <= '0;
         offset_ok <= '0;
      end else begin
         base_ok   <= base_ok | base_hit;
         offset_ok <= offset_ok | offset_hit;
         if (pop) begin
            used[head] <= 1'b0;
            head       <= (head == ptr_w'(station_depth - 1)) ? '0 : head + 1'b1;
         end
         if (push) begin
            used[tail]      <= 1'b1;
            base_ok[tail]   <= i_base_filled || in_base_hit;
            offset_ok[tail] <= i_offset_filled || in_offset_hit;
            tail            <= (tail == ptr_w'(station_depth - 1)) ? '0 : tail + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < station_depth; i++) begin
         if (base_hit[i]) base_q[i] <= i_cdb_data;
         if (offset_hit[i]) offset_q[i] <= i_cdb_data;
      end
      if (push) begin
         rob_id_q[tail]     <= i_rob_id;
         opcode_q[tail]     <= i_opcode;
         base_q[tail]       <= in_base_hit ? i_cdb_data : i_base;
         offset_q[tail]     <= in_offset_hit ? i_cdb_data : i_offset;
         base_tag_q[tail]   <= i_base_tag;
         offset_tag_q[tail] <= i_offset_tag;
      end
   end

endmodule

/* hw/store_buffer.sv */
module store_buffer #(
   parameter int sb_depth = 4
) (
   input  logic                            clk,
   input  logic                            nrst,
   input  logic                            i_push,
   input  logic [fcpu_mem_pkg::tag_w-1:0]  i_rob_id,
   input  fcpu_mem_pkg::opcode_t           i_opcode,
   input  logic [fcpu_mem_pkg::data_w-1:0] i_data,
   input  logic [fcpu_mem_pkg::tag_w-1:0]  i_data_tag,
   input  logic                            i_data_filled,
   output logic                            o_full,
   input  logic                            i_cdb_valid,
   input  logic [fcpu_mem_pkg::tag_w-1:0]  i_cdb_tag,
   input  logic [fcpu_mem_pkg::data_w-1:0] i_cdb_data,
   input  logic                            i_commit_valid,
   input  logic [fcpu_mem_pkg::tag_w-1:0]  i_commit_id,
   addr_if.mon                             addr,
   sb_head_if.src                          head
);
   localparam int ptr_w = $clog2(sb_depth);

   logic [ptr_w-1:0]                hd_ptr;
   logic [ptr_w-1:0]                tl_ptr;
   logic [sb_depth-1:0]             used;
   logic [sb_depth-1:0]             committed;
   logic [sb_depth-1:0]             data_ok;
   logic [sb_depth-1:0]             addr_ok;
   logic [sb_depth-1:0]             data_hit;
   logic [sb_depth-1:0]             addr_hit;
   logic [fcpu_mem_pkg::tag_w-1:0]  rob_id_q [sb_depth];
   fcpu_mem_pkg::opcode_t           opcode_q [sb_depth];
   logic [fcpu_mem_pkg::data_w-1:0] data_q [sb_depth];
   logic [fcpu_mem_pkg::tag_w-1:0]  data_tag_q [sb_depth];
   logic [fcpu_mem_pkg::data_w-1:0] address_q [sb_depth];
   logic                            addr_xfer;
   logic                            in_data_hit;
   logic                            head_raw;
   logic                            load_wait;
   logic                            shown_q;

   assign o_full      = &used;
   assign addr_xfer   = addr.valid && addr.ready && fcpu_mem_pkg::is_store(addr.opcode);
   assign in_data_hit = i_cdb_valid && !i_data_filled && i_cdb_tag == i_data_tag;

   always_comb begin
      for (int i = 0; i < sb_depth; i++) begin
         data_hit[i] = used[i] && !data_ok[i] && i_cdb_valid && data_tag_q[i] == i_cdb_tag;
         addr_hit[i] = used[i] && addr_xfer && rob_id_q[i] == addr.rob_id;
      end
   end

   // walk oldest to youngest, later hits override
   always_comb begin
      int idx;
      head.match_hit   = 1'b0;
      head.match_ready = 1'b0;
      head.match_data  = '0;
      for (int k = 0; k < sb_depth; k++) begin
         idx = (int'(hd_ptr) + k) % sb_depth;
         if (used[idx] && addr_ok[idx] && address_q[idx] == head.query_address) begin
            head.match_hit   = 1'b1;
            head.match_ready = data_ok[idx];
            head.match_data  = data_q[idx];
         end
      end
   end

   // a bypass load already on the memory port is not cut off by a late commit
   assign head_raw  = used[hd_ptr] && committed[hd_ptr] && addr_ok[hd_ptr] && data_ok[hd_ptr];
   assign load_wait = addr.valid && !fcpu_mem_pkg::is_store(addr.opcode) && !head.match_hit;

   assign head.head_valid   = head_raw && (shown_q || !load_wait);
   assign head.head_rob_id  = rob_id_q[hd_ptr];
   assign head.head_opcode  = opcode_q[hd_ptr];
   assign head.head_address = address_q[hd_ptr];
   assign head.head_data    = data_q[hd_ptr];

   always_ff @(posedge clk) begin
      if (nrst) begin
         hd_ptr    <= '0;
         tl_ptr    <= '0;
         used      <= '0;
         committed <= '0;
         data_ok   <= '0;
         addr_ok   <= '0;
         shown_q   <= 1'b0;
      end else begin
         shown_q <= head.head_valid && !head.pop;
         data_ok <= data_ok | data_hit;
         addr_ok <= addr_ok | addr_hit;
         for (int i = 0; i < sb_depth; i++) begin
            if (used[i] && i_commit_valid && rob_id_q[i] == i_commit_id) begin
               committed[i] <= 1'b1;
            end
         end
         if (head.pop) begin
            used[hd_ptr] <= 1'b0;
            hd_ptr       <= (hd_ptr == ptr_w'(sb_depth - 1)) ? '0 : hd_ptr + 1'b1;
         end
         if (i_push) begin
            used[tl_ptr]      <= 1'b1;
            committed[tl_ptr] <= 1'b0;
            addr_ok[tl_ptr]   <= 1'b0;
            data_ok[tl_ptr]   <= i_data_filled || in_data_hit;
            tl_ptr            <= (tl_ptr == ptr_w'(sb_depth - 1)) ? '0 : tl_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < sb_depth; i++) begin
         if (data_hit[i]) data_q[i] <= i_cdb_data;
         if (addr_hit[i]) address_q[i] <= addr.address;
      end
      if (i_push) begin
         rob_id_q[tl_ptr]   <= i_rob_id;
         opcode_q[tl_ptr]   <= i_opcode;
         data_q[tl_ptr]     <= in_data_hit ? i_cdb_data : i_data;
         data_tag_q[tl_ptr] <= i_data_tag;
      end
   end

endmodule

/* hw/mem_issue.sv */
module mem_issue (
   addr_if.dst                             addr,
   sb_head_if.dst                          head,
   output logic                            o_mem_valid,
   output fcpu_mem_pkg::opcode_t           o_mem_opcode,
   output logic [fcpu_mem_pkg::tag_w-1:0]  o_mem_rob_id,
   output logic [fcpu_mem_pkg::data_w-1:0] o_mem_address,
   output logic [fcpu_mem_pkg::data_w-1:0] o_mem_data,
   input  logic                            i_mem_ready,
   output logic                            o_cdb_valid,
   output logic [fcpu_mem_pkg::tag_w-1:0]  o_cdb_tag,
   output logic [fcpu_mem_pkg::data_w-1:0] o_cdb_data,
   input  logic                            i_cdb_ready
);
   logic addr_store;
   logic addr_load;
   logic forward;
   logic bypass;

   assign addr_store = addr.valid && fcpu_mem_pkg::is_store(addr.opcode);
   assign addr_load  = addr.valid && !fcpu_mem_pkg::is_store(addr.opcode);

   assign head.query_address = addr.address;

   assign forward = addr_load && head.match_hit && head.match_ready;
   assign bypass  = addr_load && !head.match_hit && !head.head_valid; // head store goes first

   // memory port, committed store before bypass load
   assign o_mem_valid   = head.head_valid || bypass;
   assign o_mem_opcode  = head.head_valid ? head.head_opcode : addr.opcode;
   assign o_mem_rob_id  = head.head_valid ? head.head_rob_id : addr.rob_id;
   assign o_mem_address = head.head_valid ? head.head_address : addr.address;
   assign o_mem_data    = head.head_valid ? head.head_data : addr.store_data_unused;
   assign head.pop      = head.head_valid && i_mem_ready;

   assign o_cdb_valid = forward;
   assign o_cdb_tag   = addr.rob_id;
   assign o_cdb_data  = head.match_data;

   // stores only drop their address into the buffer
   assign addr.ready = addr_store || (forward && i_cdb_ready) || (bypass && i_mem_ready);

endmodule

/* hw/memory_functional_unit.sv */
module memory_functional_unit #(
   parameter int station_depth = 4,
   parameter int sb_depth      = 4
) (
   input  logic                            clk,
   input  logic                            nrst,
   input  logic                            i_valid,
   input  logic [fcpu_mem_pkg::tag_w-1:0]  i_rob_id,
   input  fcpu_mem_pkg::opcode_t           i_opcode,
   input  logic [fcpu_mem_pkg::data_w-1:0] i_base,
   input  logic [fcpu_mem_pkg::tag_w-1:0]  i_base_tag,
   input  logic                            i_base_filled,
   input  logic [fcpu_mem_pkg::data_w-1:0] i_offset,
   input  logic [fcpu_mem_pkg::tag_w-1:0]  i_offset_tag,
   input  logic                            i_offset_filled,
   input  logic [fcpu_mem_pkg::data_w-1:0] i_data,
   input  logic [fcpu_mem_pkg::tag_w-1:0]  i_data_tag,
   input  logic                            i_data_filled,
   output logic                            o_ready,
   input  logic                            i_cdb_valid,
   input  logic [fcpu_mem_pkg::tag_w-1:0]  i_cdb_tag,
   input  logic [fcpu_mem_pkg::data_w-1:0] i_cdb_data,
   input  logic                            i_commit_valid,
   input  logic [fcpu_mem_pkg::tag_w-1:0]  i_commit_id,
   output logic                            o_cdb_valid,
   output logic [fcpu_mem_pkg::tag_w-1:0]  o_cdb_tag,
   output logic [fcpu_mem_pkg::data_w-1:0] o_cdb_data,
   input  logic                            i_cdb_ready,
   output logic                            o_mem_valid,
   output fcpu_mem_pkg::opcode_t           o_mem_opcode,
   output logic [fcpu_mem_pkg::tag_w-1:0]  o_mem_rob_id,
   output logic [fcpu_mem_pkg::data_w-1:0] o_mem_address,
   output logic [fcpu_mem_pkg::data_w-1:0] o_mem_data,
   input  logic                            i_mem_ready
);
   logic is_st;
   logic sb_full;
   logic st_ready;
   logic st_valid;
   logic sb_push;

   addr_if    addr_bus ();
   sb_head_if sb_head ();

   // a store also needs a free store buffer slot
   assign is_st    = fcpu_mem_pkg::is_store(i_opcode);
   assign o_ready  = st_ready && !(is_st && sb_full);
   assign st_valid = i_valid && !(is_st && sb_full);
   assign sb_push  = i_valid && o_ready && is_st;

   address_station #(
      .station_depth (station_depth)
   ) u_station (
      .clk             (clk),
      .nrst            (nrst),
      .i_valid         (st_valid),
      .i_rob_id        (i_rob_id),
      .i_opcode        (i_opcode),
      .i_base          (i_base),
      .i_base_tag      (i_base_tag),
      .i_base_filled   (i_base_filled),
      .i_offset        (i_offset),
      .i_offset_tag    (i_offset_tag),
      .i_offset_filled (i_offset_filled),
      .o_ready         (st_ready),
      .i_cdb_valid     (i_cdb_valid),
      .i_cdb_tag       (i_cdb_tag),
      .i_cdb_data      (i_cdb_data),
      .addr            (addr_bus.src)
   );

   store_buffer #(
      .sb_depth (sb_depth)
   ) u_store_buffer (
      .clk            (clk),
      .nrst           (nrst),
      .i_push         (sb_push),
      .i_rob_id       (i_rob_id),
      .i_opcode       (i_opcode),
      .i_data         (i_data),
      .i_data_tag     (i_data_tag),
      .i_data_filled  (i_data_filled),
      .o_full         (sb_full),
      .i_cdb_valid    (i_cdb_valid),
      .i_cdb_tag      (i_cdb_tag),
      .i_cdb_data     (i_cdb_data),
      .i_commit_valid (i_commit_valid),
      .i_commit_id    (i_commit_id),
      .addr           (addr_bus.mon),
      .head           (sb_head.src)
   );

   mem_issue u_issue (
      .addr          (addr_bus.dst),
      .head          (sb_head.dst),
      .o_mem_valid   (o_mem_valid),
      .o_mem_opcode  (o_mem_opcode),
      .o_mem_rob_id  (o_mem_rob_id),
      .o_mem_address (o_mem_address),
      .o_mem_data    (o_mem_data),
      .i_mem_ready   (i_mem_ready),
      .o_cdb_valid   (o_cdb_valid),
      .o_cdb_tag     (o_cdb_tag),
      .o_cdb_data    (o_cdb_data),
      .i_cdb_ready   (i_cdb_ready)
   );

endmodule

/* sim/tb_memory_unit_sva.sv */
module tb_memory_unit_sva (
   input logic                            clk,
   input logic                            nrst,
   input logic                            o_mem_valid,
   input fcpu_mem_pkg::opcode_t           o_mem_opcode,
   input logic [fcpu_mem_pkg::tag_w-1:0]  o_mem_rob_id,
   input logic [fcpu_mem_pkg::data_w-1:0] o_mem_address,
   input logic [fcpu_mem_pkg::data_w-1:0] o_mem_data,
   input logic                            i_mem_ready,
   input logic                            o_cdb_valid,
   input logic [fcpu_mem_pkg::tag_w-1:0]  o_cdb_tag,
   input logic [fcpu_mem_pkg::data_w-1:0] o_cdb_data,
   input logic                            i_cdb_ready
);

   mem_hold: assert property (@(posedge clk) disable iff (nrst)
      o_mem_valid && !i_mem_ready |=> o_mem_valid && $stable(o_mem_opcode) &&
      $stable(o_mem_rob_id) && $stable(o_mem_address) && $stable(o_mem_data))
      else $error("memory request changed while stalled");

   cdb_hold: assert property (@(posedge clk) disable iff (nrst)
      o_cdb_valid && !i_cdb_ready |=> o_cdb_valid && $stable(o_cdb_tag) &&
      $stable(o_cdb_data))
      else $error("cdb result changed while stalled");

   quiet_in_reset: assert property (@(posedge clk)
      nrst && $past(nrst) |-> !o_mem_valid && !o_cdb_valid)
      else $error("valid output high during reset");

   // a forwarded load never also goes to memory
   no_double_load: assert property (@(posedge clk) disable iff (nrst)
      !(o_mem_valid && !fcpu_mem_pkg::is_store(o_mem_opcode) && o_cdb_valid &&
        o_mem_rob_id == o_cdb_tag))
      else $error("load sent to memory and forwarded at once");

endmodule

/* sim/tb_memory_unit.sv */
module tb_memory_unit;
   logic                            clk;
   logic                            nrst;
   logic                            i_valid;
   logic [fcpu_mem_pkg::tag_w-1:0]  i_rob_id;
   fcpu_mem_pkg::opcode_t           i_opcode;
   logic [fcpu_mem_pkg::data_w-1:0] i_base;
   logic [fcpu_mem_pkg::tag_w-1:0]  i_base_tag;
   logic                            i_base_filled;
   logic [fcpu_mem_pkg::data_w-1:0] i_offset;
   logic [fcpu_mem_pkg::tag_w-1:0]  i_offset_tag;
   logic                            i_offset_filled;
   logic [fcpu_mem_pkg::data_w-1:0] i_data;
   logic [fcpu_mem_pkg::tag_w-1:0]  i_data_tag;
   logic                            i_data_filled;
   logic                            o_ready;
   logic                            i_cdb_valid;
   logic [fcpu_mem_pkg::tag_w-1:0]  i_cdb_tag;
   logic [fcpu_mem_pkg::data_w-1:0] i_cdb_data;
   logic                            i_commit_valid;
   logic [fcpu_mem_pkg::tag_w-1:0]  i_commit_id;
   logic                            o_cdb_valid;
   logic [fcpu_mem_pkg::tag_w-1:0]  o_cdb_tag;
   logic [fcpu_mem_pkg::data_w-1:0] o_cdb_data;
   logic                            i_cdb_ready;
   logic                            o_mem_valid;
   fcpu_mem_pkg::opcode_t           o_mem_opcode;
   logic [fcpu_mem_pkg::tag_w-1:0]  o_mem_rob_id;
   logic [fcpu_mem_pkg::data_w-1:0] o_mem_address;
   logic [fcpu_mem_pkg::data_w-1:0] o_mem_data;
   logic                            i_mem_ready;

   // expected store buffer contents oldest first
   logic [3:0]  st_rob[$];
   logic [31:0] st_addr[$];
   logic [31:0] st_data[$];

   memory_functional_unit #(.station_depth(4), .sb_depth(4)) dut (.*);

   bind memory_functional_unit tb_memory_unit_sva u_sva (
      .clk(clk), .nrst(nrst), .o_mem_valid(o_mem_valid), .o_mem_opcode(o_mem_opcode),
      .o_mem_rob_id(o_mem_rob_id), .o_mem_address(o_mem_address), .o_mem_data(o_mem_data),
      .i_mem_ready(i_mem_ready), .o_cdb_valid(o_cdb_valid), .o_cdb_tag(o_cdb_tag),
      .o_cdb_data(o_cdb_data), .i_cdb_ready(i_cdb_ready)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      #(20 * (6 * 200 + 10));
      $display("watchdog timeout, the DUT stopped responding");
      $display("Done: errors found");
      $fatal(1);
   end

   task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
      assert (got === exp) else begin
         $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
         $display("Done: errors found");
         $fatal(1);
      end
   endtask

   task automatic dispatch(input logic [3:0] rob, input fcpu_mem_pkg::opcode_t op,
                           input logic [31:0] base, input logic [3:0] btag, input logic bfill,
                           input logic [31:0] off, input logic [31:0] data,
                           input logic [3:0] dtag, input logic dfill);
      @(posedge clk);
      i_valid         <= 1'b1;
      i_rob_id        <= rob;
      i_opcode        <= op;
      i_base          <= base;
      i_base_tag      <= btag;
      i_base_filled   <= bfill;
      i_offset        <= off;
      i_offset_filled <= 1'b1;
      i_data          <= data;
      i_data_tag      <= dtag;
      i_data_filled   <= dfill;
      @(negedge clk);
      while (!o_ready) @(negedge clk);
      @(posedge clk); // accepting edge
      i_valid <= 1'b0;
   endtask

   task automatic broadcast(input logic [3:0] tag, input logic [31:0] data);
      @(posedge clk);
      i_cdb_valid <= 1'b1;
      i_cdb_tag   <= tag;
      i_cdb_data  <= data;
      @(posedge clk);
      i_cdb_valid <= 1'b0;
   endtask

   task automatic commit(input logic [3:0] id);
      @(posedge clk);
      i_commit_valid <= 1'b1;
      i_commit_id    <= id;
      @(posedge clk);
      i_commit_valid <= 1'b0;
   endtask

   task automatic expect_mem(input fcpu_mem_pkg::opcode_t op, input logic [3:0] rob,
                             input logic [31:0] addr, input logic [31:0] data);
      @(negedge clk);
      while (!o_mem_valid) @(negedge clk);
      check_eq(32'(o_mem_opcode), 32'(op), "mem opcode");
      check_eq(32'(o_mem_rob_id), 32'(rob), "mem rob id");
      check_eq(o_mem_address, addr, "mem address");
      check_eq(o_mem_data, data, "mem data");
      @(posedge clk);
   endtask

   task automatic expect_cdb(input logic [3:0] rob, input logic [31:0] data);
      @(negedge clk);
      while (!o_cdb_valid) @(negedge clk);
      check_eq(32'(o_cdb_tag), 32'(rob), "cdb tag");
      check_eq(o_cdb_data, data, "cdb data");
      check_eq(32'(o_mem_valid), 0, "mem valid during forward");
      @(posedge clk);
   endtask

   task automatic expect_idle(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         check_eq(32'(o_mem_valid), 0, "mem valid while idle");
         check_eq(32'(o_cdb_valid), 0, "cdb valid while idle");
      end
   endtask

   function automatic int youngest_store(input logic [31:0] addr);
      for (int i = st_addr.size() - 1; i >= 0; i--) begin
         if (st_addr[i] == addr) return i;
      end
      return -1;
   endfunction

   task automatic store(input logic [3:0] rob, input logic [31:0] addr, input logic [31:0] data,
                        input logic [3:0] dtag, input logic dfill);
      dispatch(rob, fcpu_mem_pkg::op_store, addr, 4'd0, 1'b1, 32'd0, data, dtag, dfill);
      st_rob.push_back(rob);
      st_addr.push_back(addr);
      st_data.push_back(data);
   endtask

   task automatic drain_store();
      expect_mem(fcpu_mem_pkg::op_store, st_rob[0], st_addr[0], st_data[0]);
      void'(st_rob.pop_front());
      void'(st_addr.pop_front());
      void'(st_data.pop_front());
   endtask

   // youngest matching store wins over memory
   task automatic run_load(input logic [3:0] rob, input logic [31:0] base,
                           input logic [31:0] off);
      int idx;
      idx = youngest_store(base + off);
      dispatch(rob, fcpu_mem_pkg::op_load, base, 4'd0, 1'b1, off, 32'd0, 4'd0, 1'b1);
      if (idx < 0) expect_mem(fcpu_mem_pkg::op_load, rob, base + off, 32'd0);
      else expect_cdb(rob, st_data[idx]);
   endtask

   task automatic test_load_bypass();
      run_load(4'd1, $urandom, $urandom);
   endtask

   task automatic test_operand_wait();
      logic [31:0] base;
      logic [31:0] off;
      base = $urandom;
      off  = $urandom;
      dispatch(4'd7, fcpu_mem_pkg::op_load, 32'd0, 4'd3, 1'b0, off, 32'd0, 4'd0, 1'b1);
      expect_idle(5);
      broadcast(4'd3, base);
      expect_mem(fcpu_mem_pkg::op_load, 4'd7, base + off, 32'd0);
   endtask

   task automatic test_store_commit();
      store(4'd1, $urandom, $urandom, 4'd0, 1'b1);
      expect_idle(5);
      commit(4'd1);
      drain_store();
      store(4'd2, $urandom, 32'd0, 4'd6, 1'b0);
      commit(4'd2);
      expect_idle(4); // data still missing
      st_data[0] = $urandom;
      broadcast(4'd6, st_data[0]);
      drain_store();
   endtask

   task automatic test_forward_youngest();
      logic [31:0] addr;
      addr = $urandom;
      store(4'd1, addr, $urandom, 4'd0, 1'b1);
      store(4'd2, addr, $urandom, 4'd0, 1'b1);
      expect_idle(3);
      run_load(4'd3, addr, 32'd0);
      commit(4'd1);
      drain_store();
      commit(4'd2);
      drain_store();
   endtask

   task automatic test_forward_pending();
      logic [31:0] addr;
      addr = $urandom;
      store(4'd4, addr, 32'd0, 4'd9, 1'b0);
      expect_idle(3);
      dispatch(4'd5, fcpu_mem_pkg::op_load, addr, 4'd0, 1'b1, 32'd0, 32'd0, 4'd0, 1'b1);
      expect_idle(5);
      st_data[0] = $urandom;
      broadcast(4'd9, st_data[0]);
      expect_cdb(4'd5, st_data[0]);
      commit(4'd4);
      drain_store();
      run_load(4'd6, addr, 32'd0);
   endtask

   task automatic test_backpressure();
      logic [31:0] addr;
      addr = $urandom;
      @(posedge clk);
      i_mem_ready <= 1'b0;
      dispatch(4'd8, fcpu_mem_pkg::op_load, addr, 4'd0, 1'b1, 32'd0, 32'd0, 4'd0, 1'b1);
      repeat (4) begin
         @(negedge clk);
         check_eq(32'(o_mem_valid), 1, "mem valid under stall");
         check_eq(o_mem_address, addr, "stalled mem address");
      end
      @(posedge clk);
      i_mem_ready <= 1'b1;
      expect_mem(fcpu_mem_pkg::op_load, 4'd8, addr, 32'd0);
      for (int i = 0; i < 4; i++) store(4'(9 + i), $urandom, $urandom, 4'd0, 1'b1);
      expect_idle(3);
      @(posedge clk);
      i_opcode <= fcpu_mem_pkg::op_store;
      @(negedge clk);
      check_eq(32'(o_ready), 0, "o_ready for store, buffer full");
      @(posedge clk);
      i_opcode <= fcpu_mem_pkg::op_load;
      @(negedge clk);
      check_eq(32'(o_ready), 1, "o_ready for load, buffer full");
      for (int i = 0; i < 4; i++) begin
         commit(4'(9 + i));
         drain_store();
      end
   endtask

   initial begin
      void'($urandom(13));
      nrst            = 1'b1;
      i_valid         = 1'b0;
      i_rob_id        = '0;
      i_opcode        = fcpu_mem_pkg::op_load;
      i_base          = '0;
      i_base_tag      = '0;
      i_base_filled   = 1'b0;
      i_offset        = '0;
      i_offset_tag    = '0;
      i_offset_filled = 1'b0;
      i_data          = '0;
      i_data_tag      = '0;
      i_data_filled   = 1'b0;
      i_cdb_valid     = 1'b0;
      i_cdb_tag       = '0;
      i_cdb_data      = '0;
      i_commit_valid  = 1'b0;
      i_commit_id     = '0;
      i_cdb_ready     = 1'b1;
      i_mem_ready     = 1'b1;
      repeat (5) @(posedge clk);
      nrst <= 1'b0;
      test_load_bypass();
      test_operand_wait();
      test_store_commit();
      test_forward_youngest();
      test_forward_pending();
      test_backpressure();
      repeat (2) @(posedge clk);
      $display("Done: no errors");
      $finish;
   end

endmodule

/* files.f */
hw/fcpu_mem_pkg.sv
hw/mem_unit_if.sv
hw/address_station.sv
hw/store_buffer.sv
hw/mem_issue.sv
hw/memory_functional_unit.sv
sim/tb_memory_unit_sva.sv
sim/tb_memory_unit.sv

/* Makefile */
TOP = tb_memory_unit
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --top-module $(TOP) -f files.f -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

lint:
	verilator --lint-only --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir $(LOG)
